// File: common/tcb_lite_pkg.sv
// TCB-Lite shared definitions
// bus widths, access size and memory phase encodings,
// request, response and lane records used across the subsystem

package tcb_lite_pkg;

    //////////////////////////////////////////////////
    // bus geometry
    //////////////////////////////////////////////////

    // byte address width
    localparam int ADR = 16;
    // data width
    localparam int DAT = 32;
    // byte lanes per word
    localparam int BYT = DAT / 8;
    // address bits that pick a lane
    localparam int MAX = $clog2(BYT);

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    // access size, log2 of the byte count
    typedef enum logic [1:0] {
        SIZ_B = 2'd0,
        SIZ_H = 2'd1,
        SIZ_W = 2'd2
    } siz_e;

    // memory phase
    typedef enum logic {
        MEM_CLEAR = 1'b0,
        MEM_RUN   = 1'b1
    } mem_state_e;

    //////////////////////////////////////////////////
    // records
    //////////////////////////////////////////////////

    // bus request, data already placed on its lanes
    typedef struct packed {
        logic           wen;
        logic [ADR-1:0] adr;
        logic [BYT-1:0] byt;
        logic [DAT-1:0] wdt;
    } req_t;

    // bus response, whole word
    typedef struct packed {
        logic [DAT-1:0] rdt;
        logic           err;
    } rsp_t;

    // what the bridge remembers per transfer for realignment
    typedef struct packed {
        logic [MAX-1:0] off;
        siz_e           siz;
        logic           wen;
    } lane_t;

endpackage

// File: common/tcb_lite_if.sv
// TCB-Lite bus interface
// valid/ready request handshake, fixed latency response,
// and the transfer delay line that marks when the response is valid

`timescale 1ns/1ps

interface tcb_lite_if #(
    parameter int DLY = 1
) (
    input logic man,
    input logic rst_n
);
    import tcb_lite_pkg::*;

    // handshake
    logic vld;
    logic rdy;

    // payload
    req_t req;
    rsp_t rsp;

    // transfer strobe and its delayed copies
    logic           trn;
    logic [DLY:0]   trn_dly;
    logic [DLY-1:0] trn_q;

    // a transfer is vld and rdy in the same cycle
    assign trn = vld && rdy;

    // bit 0 is the live transfer, bit DLY marks the response
    assign trn_dly = {trn_q, trn};

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            trn_q <= '0;
        end else begin
            trn_q <= trn_dly[DLY-1:0];
        end
    end

    //////////////////////////////////////////////////
    // views
    //////////////////////////////////////////////////

    modport mgr (
        input  man, rst_n, rdy, rsp, trn, trn_dly,
        output vld, req
    );

    modport sub (
        input  man, rst_n, vld, req, trn, trn_dly,
        output rdy, rsp
    );

    modport mon (
        input  man, rst_n, vld, rdy, req, rsp, trn, trn_dly
    );

endinterface

// File: tcb_lite_man/tcb_lite_man_bridge.sv
// TCB-Lite manager bridge
// turns byte/half/word commands into lane-steered bus requests,
// realigns the returned word and pushes it to the response queue,
// with credit flow control so a response always has a slot

`timescale 1ns/1ps

module tcb_lite_man_bridge #(
    parameter int DLY       = 1,
    parameter int RSP_DEPTH = 4
) (
    input  logic                             man,
    input  logic                             rst_n,
    input  logic                             cmd_vld,
    output logic                             cmd_rdy,
    input  logic                             cmd_wen,
    input  tcb_lite_pkg::siz_e               cmd_siz,
    input  logic [tcb_lite_pkg::ADR-1:0]     cmd_adr,
    input  logic [tcb_lite_pkg::DAT-1:0]     cmd_wdt,
    tcb_lite_if.mgr                          bus,
    output logic                             que_push,
    output tcb_lite_pkg::rsp_t               que_wdata,
    input  logic [$clog2(RSP_DEPTH+1)-1:0]   que_count
);
    import tcb_lite_pkg::*;

    localparam int CW = $clog2(RSP_DEPTH + 1);

    // transfers issued but not yet pushed
    logic [CW-1:0] fly_q;
    // one extra bit so an underflow shows as the top bit
    logic [CW:0]   credit;
    logic          has_credit;

    // realignment record pipeline
    lane_t lane_d;
    lane_t lane_q [1:DLY];

    // bytes covered by an access size
    function automatic int unsigned siz_bytes(siz_e siz);
        case (siz)
            SIZ_B:   return 1;
            SIZ_H:   return 2;
            default: return BYT;
        endcase
    endfunction

    // lane of command byte i, wraps inside the word
    function automatic logic [MAX-1:0] lane_of(int unsigned i, logic [MAX-1:0] off);
        return MAX'(i) + off;
    endfunction

    //////////////////////////////////////////////////
    // credit and handshake
    //////////////////////////////////////////////////

    assign credit     = (CW+1)'(RSP_DEPTH) - (CW+1)'(que_count) - (CW+1)'(fly_q);
    assign has_credit = (credit != '0) && !credit[CW];

    // bus vld only with credit, so every transfer is an accepted command
    assign bus.vld = cmd_vld && has_credit;
    assign cmd_rdy = bus.rdy && has_credit;

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            fly_q <= '0;
        end else begin
            fly_q <= fly_q + CW'(bus.trn) - CW'(que_push);
        end
    end

    //////////////////////////////////////////////////
    // request lane steering
    //////////////////////////////////////////////////

    always_comb begin
        bus.req.wen = cmd_wen;
        bus.req.adr = cmd_adr;
        bus.req.byt = '0;
        bus.req.wdt = '0;
        for (int unsigned i = 0; i < BYT; i++) begin
            if (i < siz_bytes(cmd_siz)) begin
                bus.req.byt[lane_of(i, cmd_adr[MAX-1:0])] = 1'b1;
                // unused lanes stay zero
                if (cmd_wen) begin
                    bus.req.wdt[8*lane_of(i, cmd_adr[MAX-1:0]) +: 8] = cmd_wdt[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // response realignment
    //////////////////////////////////////////////////

    assign lane_d = '{off: cmd_adr[MAX-1:0], siz: cmd_siz, wen: cmd_wen};

    // stage DLY lines up with trn_dly[DLY]
    always_ff @(posedge man) begin
        lane_q[1] <= lane_d;
        for (int i = 2; i <= DLY; i++) begin
            lane_q[i] <= lane_q[i-1];
        end
    end

    assign que_push = bus.trn_dly[DLY];

    always_comb begin
        que_wdata.err = bus.rsp.err;
        que_wdata.rdt = '0;
        // writes return no data
        if (!lane_q[DLY].wen) begin
            for (int unsigned i = 0; i < BYT; i++) begin
                if (i < siz_bytes(lane_q[DLY].siz)) begin
                    que_wdata.rdt[8*i +: 8] =
                        bus.rsp.rdt[8*lane_of(i, lane_q[DLY].off) +: 8];
                end
            end
        end
    end

    // credit must keep the queue from overflowing
    a_no_push_full: assert property (@(posedge man) disable iff (!rst_n)
        que_push |-> (que_count != CW'(RSP_DEPTH)))
        else $error("response pushed into a full queue");

    // stalled request must not change
    a_req_hold: assert property (@(posedge man) disable iff (!rst_n)
        (bus.vld && !bus.rdy) |=> $stable(bus.req))
        else $error("bus request changed while stalled");

endmodule

// File: rtl/tcb_lite_rsp_fifo.sv
// TCB-Lite response queue
// circular buffer holding responses in order, with occupancy count
// and a valid/ready output stream

`timescale 1ns/1ps

module tcb_lite_rsp_fifo #(
    parameter int RSP_DEPTH = 4
) (
    input  logic                             man,
    input  logic                             rst_n,
    input  logic                             push,
    input  tcb_lite_pkg::rsp_t               wdata,
    output logic [$clog2(RSP_DEPTH+1)-1:0]   count,
    output logic                             rsp_vld,
    input  logic                             rsp_rdy,
    output tcb_lite_pkg::rsp_t               rdata
);
    import tcb_lite_pkg::*;

    localparam int CW = $clog2(RSP_DEPTH + 1);
    localparam int PW = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;

    rsp_t          buf_q [RSP_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          pop;

    // pointer step, wraps for any depth
    function automatic logic [PW-1:0] ptr_next(logic [PW-1:0] ptr);
        return (ptr == PW'(RSP_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // head is valid whenever something is stored
    assign rsp_vld = (count != '0);
    assign pop     = rsp_vld && rsp_rdy;
    assign rdata   = buf_q[rd_ptr];

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge man) begin
        if (push) begin
            buf_q[wr_ptr] <= wdata;
        end
    end

    // pointers and count, push and pop may coincide
    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge man) disable iff (!rst_n)
        push |-> (count < CW'(RSP_DEPTH)))
        else $error("push into full response queue");

endmodule

// File: tcb_lite_mem/tcb_lite_sub_mem.sv
// TCB-Lite memory subordinate
// single-port word memory with byte enables and fixed read latency,
// zeroed by a sweep after reset, error on out-of-range words

`timescale 1ns/1ps

module tcb_lite_sub_mem #(
    parameter int DLY       = 1,
    parameter int MEM_WORDS = 256
) (
    input  logic    man,
    input  logic    rst_n,
    tcb_lite_if.sub bus
);
    import tcb_lite_pkg::*;

    localparam int IW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    mem_state_e         state_q;
    logic [IW-1:0]      clr_q;
    logic [DAT-1:0]     mem_q [MEM_WORDS];

    // request decode
    logic [ADR-MAX-1:0] word;
    logic [IW-1:0]      idx;
    logic               in_range;

    // response pipeline
    logic [DAT-1:0]     rdt_q [1:DLY];
    logic [DLY:1]       err_q;

    assign word     = bus.req.adr[ADR-1:MAX];
    assign idx      = IW'(word);
    assign in_range = (int'(word) < MEM_WORDS);

    // requests held off until the sweep is done
    assign bus.rdy = (state_q == MEM_RUN);

    //////////////////////////////////////////////////
    // clear sweep
    //////////////////////////////////////////////////

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MEM_CLEAR;
            clr_q   <= '0;
        end else if (state_q == MEM_CLEAR) begin
            clr_q <= clr_q + 1'b1;
            // last word written this cycle
            if (clr_q == IW'(MEM_WORDS - 1)) begin
                state_q <= MEM_RUN;
            end
        end
    end

    //////////////////////////////////////////////////
    // array
    //////////////////////////////////////////////////

    always_ff @(posedge man) begin
        if (state_q == MEM_CLEAR) begin
            mem_q[clr_q] <= '0;
        end else if (bus.trn && bus.req.wen && in_range) begin
            // only enabled lanes
            for (int b = 0; b < BYT; b++) begin
                if (bus.req.byt[b]) begin
                    mem_q[idx][8*b +: 8] <= bus.req.wdt[8*b +: 8];
                end
            end
        end
    end

    // read before write, out of range reads zero
    always_ff @(posedge man) begin
        rdt_q[1] <= in_range ? mem_q[idx] : '0;
        err_q[1] <= !in_range;
        for (int i = 2; i <= DLY; i++) begin
            rdt_q[i] <= rdt_q[i-1];
            err_q[i] <= err_q[i-1];
        end
    end

    assign bus.rsp.rdt = rdt_q[DLY];
    assign bus.rsp.err = err_q[DLY];

    // response slot must carry a defined status
    a_err_known: assert property (@(posedge man) disable iff (!rst_n)
        bus.trn_dly[DLY] |-> !$isunknown(bus.rsp.err))
        else $error("unknown err on a valid response");

endmodule

// File: rtl/tcb_lite_sys.sv
// TCB-Lite subsystem top
// command stream in, response stream out,
// bridge and memory joined by one bus, responses queued in order

`timescale 1ns/1ps

module tcb_lite_sys #(
    parameter int DLY       = 1,
    parameter int MEM_WORDS = 256,
    parameter int RSP_DEPTH = 4
) (
    input  logic                          man,
    input  logic                          rst_n,
    // command stream
    input  logic                          cmd_vld,
    output logic                          cmd_rdy,
    input  logic                          cmd_wen,
    input  tcb_lite_pkg::siz_e            cmd_siz,
    input  logic [tcb_lite_pkg::ADR-1:0]  cmd_adr,
    input  logic [tcb_lite_pkg::DAT-1:0]  cmd_wdt,
    // response stream
    output logic                          rsp_vld,
    input  logic                          rsp_rdy,
    output logic [tcb_lite_pkg::DAT-1:0]  rsp_rdt,
    output logic                          rsp_err
);
    import tcb_lite_pkg::*;

    localparam int CW = $clog2(RSP_DEPTH + 1);

    // bridge to queue
    logic          que_push;
    rsp_t          que_wdata;
    logic [CW-1:0] que_count;
    rsp_t          que_rdata;

    tcb_lite_if #(.DLY(DLY)) bus (.man(man), .rst_n(rst_n));

    tcb_lite_man_bridge #(.DLY(DLY), .RSP_DEPTH(RSP_DEPTH)) u_bridge (
        .man       (man),
        .rst_n     (rst_n),
        .cmd_vld   (cmd_vld),
        .cmd_rdy   (cmd_rdy),
        .cmd_wen   (cmd_wen),
        .cmd_siz   (cmd_siz),
        .cmd_adr   (cmd_adr),
        .cmd_wdt   (cmd_wdt),
        .bus       (bus.mgr),
        .que_push  (que_push),
        .que_wdata (que_wdata),
        .que_count (que_count)
    );

    tcb_lite_rsp_fifo #(.RSP_DEPTH(RSP_DEPTH)) u_fifo (
        .man     (man),
        .rst_n   (rst_n),
        .push    (que_push),
        .wdata   (que_wdata),
        .count   (que_count),
        .rsp_vld (rsp_vld),
        .rsp_rdy (rsp_rdy),
        .rdata   (que_rdata)
    );

    tcb_lite_sub_mem #(.DLY(DLY), .MEM_WORDS(MEM_WORDS)) u_mem (
        .man   (man),
        .rst_n (rst_n),
        .bus   (bus.sub)
    );

    // unpack queue head
    assign rsp_rdt = que_rdata.rdt;
    assign rsp_err = que_rdata.err;

endmodule

// File: bench/tcb_lite_sys_tb.sv
// TCB-Lite subsystem testbench
// directed tests of clear, word and sub-word lanes, range error,
// back-pressure ordering and latency against a reference memory model

`timescale 1ns/1ps

module tcb_lite_sys_tb;
    import tcb_lite_pkg::*;

    localparam int DLY       = 1;
    localparam int MEM_WORDS = 256;
    localparam int RSP_DEPTH = 4;
    // clear sweep plus about 300 commands at a few cycles each
    localparam int TIMEOUT   = 4000;

    logic           man;
    logic           rst_n;
    logic           cmd_vld;
    logic           cmd_rdy;
    logic           cmd_wen;
    siz_e           cmd_siz;
    logic [ADR-1:0] cmd_adr;
    logic [DAT-1:0] cmd_wdt;
    logic           rsp_vld;
    logic           rsp_rdy;
    logic [DAT-1:0] rsp_rdt;
    logic           rsp_err;

    // reference memory and expected responses in issue order
    logic [DAT-1:0] ref_mem [MEM_WORDS];
    logic [DAT-1:0] exp_rdt [$];
    logic           exp_err [$];

    logic [31:0]    rng = 32'h2832b08e;
    int             cyc;
    int             acc_cyc;
    int             rsp_cyc;

    tcb_lite_sys #(.DLY(DLY), .MEM_WORDS(MEM_WORDS), .RSP_DEPTH(RSP_DEPTH)) UUT (
        .man     (man),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .cmd_rdy (cmd_rdy),
        .cmd_wen (cmd_wen),
        .cmd_siz (cmd_siz),
        .cmd_adr (cmd_adr),
        .cmd_wdt (cmd_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdy (rsp_rdy),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    initial begin
        man = 1'b0;
        forever #2 man = ~man;
    end

    // cycle count doubles as the run limit
    always @(posedge man) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic siz_e size_from(input int unsigned k);
        case (k % 3)
            0:       return SIZ_B;
            1:       return SIZ_H;
            default: return SIZ_W;
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // byte i lands on lane (adr + i) mod BYT
    // words past MEM_WORDS give err
    task automatic model_access(input logic wen, input siz_e siz, input logic [ADR-1:0] adr,
                                input logic [DAT-1:0] wdt, output logic [DAT-1:0] rdt,
                                output logic err);
        int word;
        int n;
        int lane;
        word = int'(adr) / BYT;
        n    = (siz == SIZ_B) ? 1 : ((siz == SIZ_H) ? 2 : BYT);
        rdt  = '0;
        err  = (word >= MEM_WORDS);
        if (!err) begin
            for (int i = 0; i < n; i++) begin
                lane = (int'(adr) + i) % BYT;
                if (wen) begin
                    ref_mem[word][8*lane +: 8] = wdt[8*i +: 8];
                end else begin
                    rdt[8*i +: 8] = ref_mem[word][8*lane +: 8];
                end
            end
        end
    endtask

    // offer one command for up to max_wait cycles
    // taken commands go into the model
    task automatic offer_cmd(input logic wen, input siz_e siz, input logic [ADR-1:0] adr,
                             input logic [DAT-1:0] wdt, input int max_wait, output logic ok);
        logic [DAT-1:0] rdt;
        logic           err;
        int             waited;
        ok      = 1'b0;
        waited  = 0;
        cmd_vld = 1'b1;
        cmd_wen = wen;
        cmd_siz = siz;
        cmd_adr = adr;
        cmd_wdt = wdt;
        while (!ok && waited < max_wait) begin
            @(negedge man);
            if (cmd_rdy) begin
                ok      = 1'b1;
                acc_cyc = cyc;
            end
            waited++;
        end
        @(posedge man);
        #1;
        cmd_vld = 1'b0;
        if (ok) begin
            model_access(wen, siz, adr, wdt, rdt, err);
            exp_rdt.push_back(rdt);
            exp_err.push_back(err);
        end
    endtask

    task automatic send_cmd(input logic wen, input siz_e siz, input logic [ADR-1:0] adr,
                            input logic [DAT-1:0] wdt);
        logic ok;
        offer_cmd(wen, siz, adr, wdt, 1000, ok);
        if (!ok) begin
            $display("command at address 0x%04h was never accepted", adr);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // take the head response and compare it with the oldest expected one
    task automatic get_rsp(output logic [DAT-1:0] rdt, output logic err);
        if (exp_rdt.size() == 0) begin
            $display("response requested with no command outstanding");
            $display("Simulation failed");
            $fatal(1);
        end
        rsp_rdy = 1'b1;
        @(negedge man);
        while (!rsp_vld) begin
            @(negedge man);
        end
        rsp_cyc = cyc;
        rdt     = rsp_rdt;
        err     = rsp_err;
        check_eq("rsp_rdt", rsp_rdt, exp_rdt.pop_front());
        check_eq("rsp_err", rsp_err, exp_err.pop_front());
        @(posedge man);
        #1;
        rsp_rdy = 1'b0;
    endtask

    task automatic access(input logic wen, input siz_e siz, input logic [ADR-1:0] adr,
                          input logic [DAT-1:0] wdt, output logic [DAT-1:0] rdt,
                          output logic err);
        send_cmd(wen, siz, adr, wdt);
        get_rsp(rdt, err);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic clear_after_reset();
        logic [DAT-1:0] rdt;
        logic           err;
        @(negedge man);
        check_eq("cmd_rdy after reset", cmd_rdy, 0);
        check_eq("rsp_vld after reset", rsp_vld, 0);
        // sweep done when the bus accepts
        while (!cmd_rdy) begin
            @(negedge man);
        end
        @(posedge man);
        #1;
        for (int i = 0; i < 8; i++) begin
            access(1'b0, SIZ_W, ADR'(i * (MEM_WORDS / 8) * BYT + 4), '0, rdt, err);
            check_eq("rsp_rdt cleared", rdt, 0);
        end
    endtask

    task automatic word_round_trip();
        logic [ADR-1:0] adr [6];
        logic [DAT-1:0] rdt;
        logic           err;
        for (int i = 0; i < 6; i++) begin
            rng    = xorshift32(rng);
            adr[i] = ADR'((rng % MEM_WORDS) * BYT);
            rng    = xorshift32(rng);
            access(1'b1, SIZ_W, adr[i], rng, rdt, err);
        end
        for (int i = 0; i < 6; i++) begin
            access(1'b0, SIZ_W, adr[i], '0, rdt, err);
        end
    endtask

    // byte and half writes at every offset into a known word
    task automatic sub_word_lanes();
        logic [ADR-1:0] base;
        logic [DAT-1:0] rdt;
        logic           err;
        for (int off = 0; off < BYT; off++) begin
            base = ADR'((32 + off) * BYT);
            rng  = xorshift32(rng);
            access(1'b1, SIZ_W, base, 32'h11223344, rdt, err);
            access(1'b1, SIZ_B, base + ADR'(off), rng, rdt, err);
            access(1'b0, SIZ_W, base, '0, rdt, err);
            access(1'b0, SIZ_B, base + ADR'(off), '0, rdt, err);
            base = ADR'((40 + off) * BYT);
            access(1'b1, SIZ_W, base, 32'h11223344, rdt, err);
            access(1'b1, SIZ_H, base + ADR'(off), 32'h5A5ABEEF, rdt, err);
            access(1'b0, SIZ_W, base, '0, rdt, err);
            // half at offset 3 puts its upper byte on lane 0
            if (off == BYT - 1) begin
                check_eq("rsp_rdt half wrap", rdt, 32'hEF2233BE);
            end
            access(1'b0, SIZ_H, base + ADR'(off), '0, rdt, err);
        end
    endtask

    task automatic range_error();
        logic [DAT-1:0] rdt;
        logic           err;
        access(1'b1, SIZ_W, '0, 32'hCAFE0001, rdt, err);
        // word MEM_WORDS would alias word 0 if the range were ignored
        access(1'b1, SIZ_W, ADR'(MEM_WORDS * BYT), 32'hDEAD0000, rdt, err);
        check_eq("rsp_err write out of range", err, 1);
        access(1'b0, SIZ_W, ADR'(MEM_WORDS * BYT), '0, rdt, err);
        check_eq("rsp_err read out of range", err, 1);
        check_eq("rsp_rdt read out of range", rdt, 0);
        access(1'b1, SIZ_B, ADR'(MEM_WORDS * BYT + 1), 32'h000000AA, rdt, err);
        access(1'b0, SIZ_H, 16'hFFFC, '0, rdt, err);
        access(1'b0, SIZ_W, '0, '0, rdt, err);
        check_eq("rsp_rdt word 0 untouched", rdt, 32'hCAFE0001);
    endtask

    task automatic back_pressure();
        logic [DAT-1:0] rdt;
        logic           err;
        logic           ok;
        int             taken;
        taken = 0;
        ok    = 1'b1;
        // offer with rsp_rdy low until the bridge stops taking commands
        while (ok && taken < 2 * RSP_DEPTH) begin
            rng = xorshift32(rng);
            offer_cmd(rng[0], size_from(rng[7:4]), ADR'((rng[31:16] % MEM_WORDS) * BYT),
                      xorshift32(rng), 8, ok);
            if (ok) begin
                taken++;
            end
        end
        check_eq("commands taken within depth", taken <= RSP_DEPTH, 1);
        @(negedge man);
        check_eq("cmd_rdy under back-pressure", cmd_rdy, 0);
        @(posedge man);
        #1;
        for (int i = 0; i < taken; i++) begin
            get_rsp(rdt, err);
        end
    endtask

    // random commands in bursts of up to RSP_DEPTH drained in order
    task automatic random_traffic(input int n);
        logic [DAT-1:0] rdt;
        logic           err;
        int             done;
        int             batch;
        done = 0;
        while (done < n) begin
            rng   = xorshift32(rng);
            batch = 1 + int'(rng % RSP_DEPTH);
            if (batch > n - done) begin
                batch = n - done;
            end
            for (int k = 0; k < batch; k++) begin
                rng = xorshift32(rng);
                send_cmd(rng[0], size_from(rng[7:4]),
                         ADR'(rng[31:16] % (MEM_WORDS * BYT + 64)), xorshift32(rng));
            end
            for (int k = 0; k < batch; k++) begin
                get_rsp(rdt, err);
            end
            done += batch;
        end
    endtask

    task automatic read_latency();
        logic [DAT-1:0] rdt;
        logic           err;
        // queue is empty and the consumer is ready
        rsp_rdy = 1'b1;
        send_cmd(1'b0, SIZ_W, ADR'(3 * BYT), '0);
        get_rsp(rdt, err);
        check_eq("rsp_vld latency", rsp_cyc - acc_cyc, DLY + 1);
    endtask

    //////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////

    initial begin
        cyc     = 0;
        acc_cyc = 0;
        rsp_cyc = 0;
        rst_n   = 1'b0;
        cmd_vld = 1'b0;
        cmd_wen = 1'b0;
        cmd_siz = SIZ_B;
        cmd_adr = '0;
        cmd_wdt = '0;
        rsp_rdy = 1'b0;
        // memory reads zero once the sweep is done
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (16) @(posedge man);
        #1;
        rst_n = 1'b1;

        clear_after_reset();
        word_round_trip();
        sub_word_lanes();
        range_error();
        back_pressure();
        random_traffic(200);
        read_latency();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: tcb_lite_sys.f
common/tcb_lite_pkg.sv
common/tcb_lite_if.sv
tcb_lite_man/tcb_lite_man_bridge.sv
rtl/tcb_lite_rsp_fifo.sv
tcb_lite_mem/tcb_lite_sub_mem.sv
rtl/tcb_lite_sys.sv
bench/tcb_lite_sys_tb.sv

// File: Bender.yml
package:
  name: tcb_lite_sys

sources:
  # synthesizable sources, also needed by the bench
  - target: any(rtl, bench)
    files:
      - common/tcb_lite_pkg.sv
      - common/tcb_lite_if.sv
      - tcb_lite_man/tcb_lite_man_bridge.sv
      - rtl/tcb_lite_rsp_fifo.sv
      - tcb_lite_mem/tcb_lite_sub_mem.sv
      - rtl/tcb_lite_sys.sv

  # directed testbench
  - target: bench
    files:
      - bench/tcb_lite_sys_tb.sv
